// ==== bench/tb_noc_router.sv ====
// ####################
// NoC router testbench
// Random wormhole traffic on all ports, scoreboard per source and output
// ####################
`timescale 1ns/100ps
`default_nettype none

module tb_noc_router;

  localparam int NumPorts = noc_pkg::NumPorts;
  localparam int NumPkts  = 12;
  localparam logic [1:0] RouterX = 2'd1;
  localparam logic [1:0] RouterY = 2'd2;

  logic                          clk_i;
  logic                          rst_n_i;
  noc_pkg::flit_t [NumPorts-1:0] flit_i;
  noc_pkg::flit_t [NumPorts-1:0] flit_o;
  logic [NumPorts-1:0]           valid_i, ready_o, valid_o, ready_i;

  logic [31:0]         lfsr_state;
  int                  pkt_len [NumPorts][NumPkts];
  logic [3:0]          pkt_dst [NumPorts][NumPkts];
  int                  pkt_idx [NumPorts];
  int                  flit_idx [NumPorts];
  int                  seq [NumPorts];
  int                  cur_src [NumPorts];
  noc_pkg::flit_t      held_flit [NumPorts];
  logic [NumPorts-1:0] accepted, in_pkt, stalled;
  int                  total_flits;
  int                  cycles;

  // Expected flits, indexed by source * NumPorts + output
  noc_pkg::flit_t exp_q [NumPorts*NumPorts][$];

  noc_router #(
    .FifoDepth ( 4 )
  ) uut (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .x_i     ( RouterX ),
    .y_i     ( RouterY ),
    .flit_i  ( flit_i  ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .flit_o  ( flit_o  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  // Reference XY rule, dst is {x, y}
  function automatic int xy_route(input logic [3:0] dst);
    if (dst[3:2] > RouterX) return int'(noc_pkg::East);
    if (dst[3:2] < RouterX) return int'(noc_pkg::West);
    if (dst[1:0] > RouterY) return int'(noc_pkg::North);
    if (dst[1:0] < RouterY) return int'(noc_pkg::South);
    return int'(noc_pkg::Local);
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic plan_traffic();
    total_flits = 0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int k = 0; k < NumPkts; k++) begin
        pkt_len[p][k] = int'(rand_bits(2)) + 1;
        total_flits   += pkt_len[p][k];
        // Redraw until the packet leaves by another port
        do begin
          pkt_dst[p][k] = 4'(rand_bits(4));
        end while (xy_route(pkt_dst[p][k]) == p);
      end
    end
  endtask

  function automatic logic all_sent();
    for (int p = 0; p < NumPorts; p++) begin
      if (pkt_idx[p] < NumPkts || valid_i[p]) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic logic queues_empty();
    for (int q = 0; q < NumPorts * NumPorts; q++) begin
      if (exp_q[q].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic drive_ports();
    logic last;
    for (int p = 0; p < NumPorts; p++) begin
      // A raised valid stays until the flit is taken
      if (!valid_i[p] || accepted[p]) begin
        valid_i[p] = 1'b0;
        if (pkt_idx[p] < NumPkts && rand_bits(1) == 32'd1) begin
          last       = (flit_idx[p] + 1 == pkt_len[p][pkt_idx[p]]);
          valid_i[p] = 1'b1;
          flit_i[p]  = {last, pkt_dst[p][pkt_idx[p]], 3'(p), 8'(seq[p])};
        end
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      ready_i[o] = (rand_bits(2) != 32'd0);
    end
  endtask

  task automatic sample_ports();
    noc_pkg::flit_t got;
    int             src;
    for (int p = 0; p < NumPorts; p++) begin
      accepted[p] = valid_i[p] & ready_o[p];
      if (accepted[p]) begin
        exp_q[p*NumPorts + xy_route(flit_i[p][14:11])].push_back(flit_i[p]);
        seq[p]++;
        flit_idx[p]++;
        if (flit_idx[p] == pkt_len[p][pkt_idx[p]]) begin
          flit_idx[p] = 0;
          pkt_idx[p]++;
        end
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      // Held flit under back-pressure
      if (stalled[o]) begin
        check_value($sformatf("valid_o[%0d]", o), 32'(valid_o[o]), 32'd1);
        check_value($sformatf("flit_o[%0d]", o), 32'(flit_o[o]), 32'(held_flit[o]));
      end
      stalled[o]   = valid_o[o] & ~ready_i[o];
      held_flit[o] = flit_o[o];
      if (valid_o[o] && ready_i[o]) begin
        got = flit_o[o];
        src = int'(got[10:8]);
        if (src >= NumPorts || src == o) begin
          fail_run($sformatf("Output %0d delivered a flit from invalid source %0d", o, src));
        end else if (exp_q[src*NumPorts + o].size() == 0) begin
          fail_run($sformatf("Output %0d delivered an unexpected flit from source %0d",
                             o, src));
        end else begin
          if (in_pkt[o]) begin
            check_value($sformatf("packet source on output %0d", o), 32'(src),
                        32'(cur_src[o]));
          end
          check_value($sformatf("flit_o[%0d]", o), 32'(got),
                      32'(exp_q[src*NumPorts + o].pop_front()));
          in_pkt[o]  = ~got[15];
          cur_src[o] = src;
        end
      end
    end
  endtask

  initial begin
    lfsr_state = 32'h7067;
    rst_n_i    = 1'b0;
    valid_i    = '0;
    flit_i     = '0;
    ready_i    = '0;
    accepted   = '0;
    in_pkt     = '0;
    stalled    = '0;
    for (int p = 0; p < NumPorts; p++) begin
      pkt_idx[p]   = 0;
      flit_idx[p]  = 0;
      seq[p]       = 0;
      cur_src[p]   = 0;
      held_flit[p] = '0;
    end
    plan_traffic();
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("valid_o", 32'(valid_o), 32'd0);
    check_value("ready_o", 32'(ready_o), 32'h1f);

    cycles = 0;
    while (!(all_sent() && queues_empty()) && cycles < total_flits * 20) begin
      @(posedge clk_i);
      #1;
      drive_ports();
      @(negedge clk_i);
      sample_ports();
      cycles++;
    end

    if (all_sent() && queues_empty()) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run($sformatf("Timeout after %0d cycles with flits still undelivered", cycles));
    end
  end

endmodule

`default_nettype wire

// ==== rtl/flit_fifo.sv ====
// ####################
// Flit FIFO
// Circular input buffer, valid/ready on both sides
// ####################
`timescale 1ns/100ps
`default_nettype none

module flit_fifo #(
  parameter int unsigned Depth = 4
) (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  input  wire noc_pkg::flit_t  flit_i,
  input  wire                  valid_i,
  output logic                 ready_o,
  output noc_pkg::flit_t       flit_o,
  output logic                 valid_o,
  input  wire                  ready_i
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  noc_pkg::flit_t mem [Depth];
  ptr_t           wr_ptr_q, rd_ptr_q;
  cnt_t           count_q;
  logic           full, push, pop;

  // Wrap explicitly so any depth works
  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count_q == cnt_t'(Depth));
  // A full buffer still takes a flit when its head leaves this cycle
  assign ready_o = ~full | ready_i;
  assign valid_o = (count_q != '0);
  assign flit_o  = mem[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/noc_pkg.sv ====
// ####################
// NoC router shared definitions
// Port order, mesh coordinates and flit layout
// ####################
`default_nettype none

package noc_pkg;

  localparam int unsigned NumPorts = 5;

  // Values double as port indices
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } port_e;

  // 4x4 mesh
  typedef logic [1:0] coord_t;

  typedef logic [15:0] flit_t;

  typedef logic [NumPorts-1:0] route_mask_t;

  // Flit fields
  localparam int unsigned LastBit      = 15;
  localparam int unsigned DstXLsb      = 13;
  localparam int unsigned DstYLsb      = 11;
  localparam int unsigned PayloadWidth = 11;

  typedef logic [PayloadWidth-1:0] payload_t;

  function automatic logic flit_last(flit_t f);
    return f[LastBit];
  endfunction

  function automatic coord_t flit_dst_x(flit_t f);
    return f[DstXLsb +: 2];
  endfunction

  function automatic coord_t flit_dst_y(flit_t f);
    return f[DstYLsb +: 2];
  endfunction

  function automatic payload_t flit_payload(flit_t f);
    return f[PayloadWidth-1:0];
  endfunction

endpackage

`default_nettype wire

// ==== rtl/noc_router.sv ====
// ####################
// Five-port mesh NoC router
// Input buffers, XY routing, wormhole output arbiters
// ####################
`timescale 1ns/100ps
`default_nettype none

module noc_router #(
  parameter int unsigned FifoDepth = 4
) (
  input  wire                                          clk_i,
  input  wire                                          rst_n_i,
  input  wire noc_pkg::coord_t                         x_i,
  input  wire noc_pkg::coord_t                         y_i,

  input  wire noc_pkg::flit_t [noc_pkg::NumPorts-1:0]  flit_i,
  input  wire [noc_pkg::NumPorts-1:0]                  valid_i,
  output logic [noc_pkg::NumPorts-1:0]                 ready_o,

  output noc_pkg::flit_t [noc_pkg::NumPorts-1:0]       flit_o,
  output logic [noc_pkg::NumPorts-1:0]                 valid_o,
  input  wire [noc_pkg::NumPorts-1:0]                  ready_i
);

  localparam int unsigned NumPorts = noc_pkg::NumPorts;
  // Loopback is not wired, so each output sees one input less
  localparam int unsigned NumIn    = NumPorts - 1;

  noc_pkg::flit_t       [NumPorts-1:0] head_flit;
  logic                 [NumPorts-1:0] head_valid;
  logic                 [NumPorts-1:0] pop;
  noc_pkg::route_mask_t [NumPorts-1:0] route;

  // Indexed [input][output]
  logic [NumPorts-1:0][NumPorts-1:0] grant_ready;

  // Per output, compressed to the inputs other than its own
  logic           [NumPorts-1:0][NumIn-1:0] arb_valid;
  logic           [NumPorts-1:0][NumIn-1:0] arb_ready;
  noc_pkg::flit_t [NumPorts-1:0][NumIn-1:0] arb_flit;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    flit_fifo #(
      .Depth ( FifoDepth )
    ) i_flit_fifo (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .flit_i  ( flit_i[i]     ),
      .valid_i ( valid_i[i]    ),
      .ready_o ( ready_o[i]    ),
      .flit_o  ( head_flit[i]  ),
      .valid_o ( head_valid[i] ),
      .ready_i ( pop[i]        )
    );

    xy_route_select i_route_select (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .x_i     ( x_i           ),
      .y_i     ( y_i           ),
      .flit_i  ( head_flit[i]  ),
      .valid_i ( head_valid[i] ),
      .pop_i   ( pop[i]        ),
      .route_o ( route[i]      )
    );

    // Pop when the output this input routes to accepts its flit
    assign pop[i] = |(grant_ready[i] & route[i]);
  end

  // Crossbar between inputs and arbiters
  for (genvar o = 0; o < NumPorts; o++) begin : gen_xbar_out
    for (genvar i = 0; i < NumPorts; i++) begin : gen_xbar_in
      if (i == o) begin : gen_no_loop
        assign grant_ready[i][o] = 1'b0;
      end else begin : gen_link
        localparam int unsigned Slot = (i < o) ? i : i - 1;
        assign arb_valid[o][Slot] = head_valid[i] & route[i][o];
        assign arb_flit[o][Slot]  = head_flit[i];
        assign grant_ready[i][o]  = arb_ready[o][Slot];
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    wormhole_arbiter #(
      .NumIn ( NumIn )
    ) i_wormhole_arbiter (
      .clk_i   ( clk_i        ),
      .rst_n_i ( rst_n_i      ),
      .valid_i ( arb_valid[o] ),
      .flit_i  ( arb_flit[o]  ),
      .ready_o ( arb_ready[o] ),
      .valid_o ( valid_o[o]   ),
      .flit_o  ( flit_o[o]    ),
      .ready_i ( ready_i[o]   )
    );
  end

endmodule

`default_nettype wire

// ==== rtl/wormhole_arbiter.sv ====
// ####################
// Wormhole arbiter
// Round-robin grant, locked until the last flit
// ####################
`timescale 1ns/100ps
`default_nettype none

module wormhole_arbiter #(
  parameter int unsigned NumIn = 4
) (
  input  wire                              clk_i,
  input  wire                              rst_n_i,
  input  wire [NumIn-1:0]                  valid_i,
  input  wire noc_pkg::flit_t [NumIn-1:0]  flit_i,
  output logic [NumIn-1:0]                 ready_o,
  output logic                             valid_o,
  output noc_pkg::flit_t                   flit_o,
  input  wire                              ready_i
);

  localparam int unsigned IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  typedef logic [IdxW-1:0] idx_t;

  idx_t gnt_idx;
  idx_t last_q, lock_idx_q;
  logic gnt_valid;
  logic locked_q;

  always_comb begin
    int cand;
    cand      = 0;
    gnt_idx   = lock_idx_q;
    gnt_valid = 1'b0;
    if (locked_q) begin
      gnt_valid = valid_i[lock_idx_q];
    end else begin
      // Search starts one past the last winner
      for (int i = 1; i <= int'(NumIn); i++) begin
        cand = (int'(last_q) + i) % int'(NumIn);
        if (!gnt_valid && valid_i[cand]) begin
          gnt_valid = 1'b1;
          gnt_idx   = idx_t'(cand);
        end
      end
    end
  end

  assign valid_o = gnt_valid;
  assign flit_o  = flit_i[gnt_idx];

  always_comb begin
    ready_o          = '0;
    ready_o[gnt_idx] = ready_i & gnt_valid;
  end

  // A stalled flit also locks, so the output cannot switch under back-pressure
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
      last_q     <= idx_t'(NumIn - 1);
    end else if (valid_o) begin
      lock_idx_q <= gnt_idx;
      if (ready_i) begin
        last_q   <= gnt_idx;
        locked_q <= ~noc_pkg::flit_last(flit_o);
      end else begin
        locked_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/xy_route_select.sv ====
// ####################
// XY route select
// Dimension-order route per input, held per packet
// ####################
`timescale 1ns/100ps
`default_nettype none

module xy_route_select (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire noc_pkg::coord_t    x_i,
  input  wire noc_pkg::coord_t    y_i,
  input  wire noc_pkg::flit_t     flit_i,
  input  wire                     valid_i,
  input  wire                     pop_i,
  output noc_pkg::route_mask_t    route_o
);

  noc_pkg::route_mask_t head_route;
  noc_pkg::route_mask_t route_q;
  noc_pkg::coord_t      dst_x, dst_y;
  logic                 in_packet_q;
  logic                 popped;

  assign dst_x  = noc_pkg::flit_dst_x(flit_i);
  assign dst_y  = noc_pkg::flit_dst_y(flit_i);
  assign popped = valid_i & pop_i;

  // X first, then Y
  always_comb begin
    head_route = '0;
    if (dst_x > x_i) begin
      head_route[noc_pkg::East] = 1'b1;
    end else if (dst_x < x_i) begin
      head_route[noc_pkg::West] = 1'b1;
    end else if (dst_y > y_i) begin
      head_route[noc_pkg::North] = 1'b1;
    end else if (dst_y < y_i) begin
      head_route[noc_pkg::South] = 1'b1;
    end else begin
      head_route[noc_pkg::Local] = 1'b1;
    end
  end

  // Body flits follow the route taken by their head
  assign route_o = in_packet_q ? route_q : head_route;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_packet_q <= 1'b0;
      route_q     <= '0;
    end else if (popped) begin
      if (noc_pkg::flit_last(flit_i)) begin
        in_packet_q <= 1'b0;
      end else if (!in_packet_q) begin
        in_packet_q <= 1'b1;
        route_q     <= head_route;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the router testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_noc_router -f src.f \
  -o sim_noc_router \
  && ./obj_dir/sim_noc_router > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASS$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== src.f ====
rtl/noc_pkg.sv
rtl/flit_fifo.sv
rtl/xy_route_select.sv
rtl/wormhole_arbiter.sv
rtl/noc_router.sv
bench/tb_noc_router.sv
